/* fetch_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_checker #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic         pause,
    input  wire logic         branch_flush,
    input  wire logic [31:0]  branch_target,
    input  wire logic         cacop_en,
    input  wire logic [1:0]   cacop_mode,
    input  wire logic [31:0]  cacop_addr,
    input  wire logic         rd_req,
    input  wire logic [31:0]  rd_addr,
    input  wire logic         ret_valid,
    input  wire logic [31:0]  inst,
    input  wire logic [31:0]  inst_pc,
    input  wire logic         inst_valid
);

    string test_name = "reset";
    int    errors = 0;
    int    refills = 0;

    logic [31:0] exp_pc;
    logic        rd_req_q;
    logic        cacop_q;
    int          hit_way;
    logic [6:0]  idx;

    // two-way tag model with one lru bit per set naming the next victim
    logic [19:0] tag_m [2][128];
    logic        val_m [2][128];
    logic        lru_m [128];

    // instruction word stored at a byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[24:0], addr[31:25]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic int find_way(input logic [31:0] addr);
        for (int w = 0; w < 2; w++) begin
            if (val_m[w][addr[11:5]] && tag_m[w][addr[11:5]] == addr[31:12]) begin
                return w;
            end
        end
        return -1;
    endfunction

    always @(negedge clk) begin
        if (reset) begin
            exp_pc   = RESET_PC;
            rd_req_q = 1'b0;
            cacop_q  = 1'b0;
            for (int i = 0; i < 128; i++) begin
                val_m[0][i] = 1'b0;
                val_m[1][i] = 1'b0;
                lru_m[i]    = 1'b0;
            end
        end else begin
            if (inst_valid) begin
                if (pause) begin
                    $display("%s: instruction at %h delivered while paused", test_name, inst_pc);
                    errors++;
                end
                if (inst !== mem_word(inst_pc)) begin
                    $display("Fail %s inst at %h expected %h actual %h",
                             test_name, inst_pc, mem_word(inst_pc), inst);
                    errors++;
                end
                if (inst_pc !== exp_pc) begin
                    $display("Fail %s inst_pc expected %h actual %h", test_name, exp_pc, inst_pc);
                    errors++;
                end
                if (!ret_valid) begin
                    hit_way = find_way(inst_pc);
                    if (hit_way < 0) begin
                        $display("%s: hit at %h on a line the tag model does not hold",
                                 test_name, inst_pc);
                        errors++;
                    end else begin
                        lru_m[inst_pc[11:5]] = (hit_way == 0);
                    end
                end
                exp_pc = inst_pc + 32'd4;
            end
            if (rd_req && !rd_req_q) begin
                refills++;
                // the missing fetch is the next one expected
                if (rd_addr[31:5] !== exp_pc[31:5]) begin
                    $display("Fail %s rd_addr line expected %h actual %h", test_name,
                             {exp_pc[31:5], 5'd0}, {rd_addr[31:5], 5'd0});
                    errors++;
                end
                if (find_way(rd_addr) >= 0) begin
                    $display("%s: refill requested at %h for a line already cached",
                             test_name, rd_addr);
                    errors++;
                end
            end
            // a pending invalidation blocks the refill write
            if (ret_valid && !cacop_q) begin
                idx = rd_addr[11:5];
                tag_m[lru_m[idx]][idx] = rd_addr[31:12];
                val_m[lru_m[idx]][idx] = 1'b1;
                lru_m[idx] = !lru_m[idx];
            end
            if (branch_flush) begin
                exp_pc = branch_target;
            end
            if (cacop_en && cacop_mode != 2'd3) begin
                val_m[0][cacop_addr[11:5]] = 1'b0;
                val_m[1][cacop_addr[11:5]] = 1'b0;
            end
            rd_req_q = rd_req;
            cacop_q  = cacop_en && cacop_mode != 2'd3;
        end
    end

endmodule

`default_nettype wire

/* fetch_pc.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_pc #(
    parameter icache_pkg::addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              pause,
    input  logic              branch_flush,
    input  icache_pkg::addr_t branch_target,
    pc_icache_if.front        fetch_if
);
    import icache_pkg::*;

    addr_t pc_q;
    logic  inst_en_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_en_q <= 1'b0;
        end else begin
            inst_en_q <= 1'b1;
        end
    end

    // redirect wins over stall and pause
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (branch_flush) begin
            pc_q <= branch_target;
        end else if (inst_en_q && !(fetch_if.stall || pause)) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign fetch_if.pc      = pc_q;
    assign fetch_if.inst_en = inst_en_q;

endmodule

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_top #(
    parameter icache_pkg::addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pause,
    input  logic                    branch_flush,
    input  icache_pkg::addr_t       branch_target,
    input  logic                    cacop_en,
    input  icache_pkg::cacop_mode_t cacop_mode,
    input  icache_pkg::addr_t       cacop_addr,
    output logic                    rd_req,
    output icache_pkg::addr_t       rd_addr,
    input  logic                    ret_valid,
    input  icache_pkg::line_t       ret_data,
    output icache_pkg::word_t       inst,
    output icache_pkg::addr_t       inst_pc,
    output logic                    inst_valid
);

    pc_icache_if fetch_if ();

    fetch_pc #(
        .RESET_PC (RESET_PC)
    ) u_fetch_pc (
        .clk           (clk),
        .reset         (reset),
        .pause         (pause),
        .branch_flush  (branch_flush),
        .branch_target (branch_target),
        .fetch_if      (fetch_if.front)
    );

    icache u_icache (
        .clk          (clk),
        .reset        (reset),
        .pause        (pause),
        .branch_flush (branch_flush),
        .fetch_if     (fetch_if.cache),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .cacop_en     (cacop_en),
        .cacop_mode   (cacop_mode),
        .cacop_addr   (cacop_addr)
    );

    // fetched instruction out to the decode stage
    assign inst       = fetch_if.inst;
    assign inst_pc    = fetch_if.pc_out;
    assign inst_valid = fetch_if.inst_valid;

endmodule

`default_nettype wire

/* icache.sv */
`timescale 1ns/10ps
`default_nettype none

module icache (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pause,
    input  logic                    branch_flush,
    pc_icache_if.cache              fetch_if,
    output logic                    rd_req,
    output icache_pkg::addr_t       rd_addr,
    input  logic                    ret_valid,
    input  icache_pkg::line_t       ret_data,
    input  logic                    cacop_en,
    input  icache_pkg::cacop_mode_t cacop_mode,
    input  icache_pkg::addr_t       cacop_addr
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_REFILL,
        S_SETTLE
    } state_t;

    state_t state;
    state_t state_nxt;

    logic   stall;
    logic   req_valid;
    addr_t  req_addr;
    index_t req_index;

    logic   cacop_pend;
    index_t cacop_index;

    index_t rd_index;
    index_t wr_index;
    tagv_t  wr_tagv;
    logic   wr_hazard;

    logic [1:0] way_wr;
    logic [1:0] way_hit;
    word_t      way_word [2];

    logic [NUM_SETS-1:0] lru;
    logic  victim;
    logic  hit_any;
    logic  lookup_hit;
    logic  miss;
    logic  refill_done;
    logic  refill_wr;
    word_t ret_word;

    assign req_index = index_of(req_addr);

    always_ff @(posedge clk) begin
        if (reset || branch_flush) begin
            req_valid <= 1'b0;
        end else if (refill_done && !pause) begin
            // missed word already went out with ret_data
            req_valid <= 1'b0;
        end else if (!(stall || pause)) begin
            req_valid <= fetch_if.inst_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!(stall || pause)) begin
            req_addr <= fetch_if.pc;
        end
    end

    // modes 0..2 all invalidate the index in both ways
    always_ff @(posedge clk) begin
        if (reset) begin
            cacop_pend <= 1'b0;
        end else begin
            cacop_pend <= cacop_en && (cacop_mode inside {2'd0, 2'd1, 2'd2});
        end
    end

    always_ff @(posedge clk) begin
        cacop_index <= index_of(cacop_addr);
    end

    // keep the ram on the held request while it cannot move on
    assign rd_index = (stall || pause) ? req_index : index_of(fetch_if.pc);

    assign victim      = lru[req_index];
    assign hit_any     = (|way_hit) && !wr_hazard;
    assign lookup_hit  = (state == S_LOOKUP) && req_valid && !cacop_pend && hit_any;
    assign miss        = (state == S_LOOKUP) && req_valid && !cacop_pend && !hit_any;
    assign refill_done = (state == S_REFILL) && ret_valid;
    assign refill_wr   = refill_done && !cacop_pend;

    assign way_wr[0] = cacop_pend || (refill_wr && !victim);
    assign way_wr[1] = cacop_pend || (refill_wr && victim);
    assign wr_index  = cacop_pend ? cacop_index : req_index;
    assign wr_tagv   = cacop_pend ? '0 : {1'b1, tag_of(req_addr)};

    // tag read issued under a write to the same set saw stale data
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_hazard <= 1'b0;
        end else begin
            wr_hazard <= (|way_wr) && (wr_index == rd_index);
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_way u_way (
            .clk      (clk),
            .rd_index (rd_index),
            .wr_en    (way_wr[w]),
            .wr_index (wr_index),
            .wr_tagv  (wr_tagv),
            .wr_line  (ret_data),
            .cmp_tag  (tag_of(req_addr)),
            .word_sel (word_of(req_addr)),
            .hit      (way_hit[w]),
            .word     (way_word[w])
        );
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_LOOKUP: begin
                if (miss && !branch_flush) begin
                    state_nxt = S_REFILL;
                end
            end
            S_REFILL: begin
                if (ret_valid) begin
                    state_nxt = S_SETTLE;
                end
            end
            default: begin
                state_nxt = S_LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_LOOKUP;
        end else begin
            state <= state_nxt;
        end
    end

    // bit names the next victim, so point it away from the way just used
    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (lookup_hit) begin
            lru[req_index] <= way_hit[0];
        end else if (refill_wr) begin
            lru[req_index] <= ~victim;
        end
    end

    assign ret_word = ret_data[word_of(req_addr)*$bits(word_t) +: $bits(word_t)];

    assign stall = reset || cacop_pend || miss || (state != S_LOOKUP);

    assign fetch_if.stall      = stall;
    assign fetch_if.inst_valid = req_valid && !pause && (lookup_hit || refill_done);
    assign fetch_if.inst       = (state == S_REFILL) ? ret_word :
                                 way_hit[1]          ? way_word[1] : way_word[0];
    assign fetch_if.pc_out     = req_addr;

    assign rd_req  = (state == S_REFILL) && !ret_valid;
    assign rd_addr = req_addr;

endmodule

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    localparam int NUM_SETS       = 128;
    localparam int WORDS_PER_LINE = 8;

    // address field widths
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 7;
    localparam int WSEL_W   = 3;
    localparam int OFFSET_W = WSEL_W + 2;

    typedef logic [31:0]                  addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [INDEX_W-1:0]           index_t;
    typedef logic [WSEL_W-1:0]            word_sel_t;
    // valid bit sits above the tag
    typedef logic [TAG_W:0]               tagv_t;
    typedef logic [1:0]                   cacop_mode_t;

    function automatic tag_t tag_of(addr_t addr);
        return addr[OFFSET_W+INDEX_W +: TAG_W];
    endfunction

    function automatic index_t index_of(addr_t addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    function automatic word_sel_t word_of(addr_t addr);
        return addr[2 +: WSEL_W];
    endfunction

endpackage

`default_nettype wire

/* icache_way.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_way (
    input  logic                  clk,
    input  icache_pkg::index_t    rd_index,
    input  logic                  wr_en,
    input  icache_pkg::index_t    wr_index,
    input  icache_pkg::tagv_t     wr_tagv,
    input  icache_pkg::line_t     wr_line,
    input  icache_pkg::tag_t      cmp_tag,
    input  icache_pkg::word_sel_t word_sel,
    output logic                  hit,
    output icache_pkg::word_t     word
);
    import icache_pkg::*;

    word_t bank_q [WORDS_PER_LINE];
    tagv_t tagv_q;

    // one bank per word of the line
    for (genvar i = 0; i < WORDS_PER_LINE; i++) begin : g_bank
        simple_dual_port_ram #(
            .WIDTH ($bits(word_t)),
            .DEPTH (NUM_SETS)
        ) u_bank (
            .clk     (clk),
            .wr_en   (wr_en),
            .wr_addr (wr_index),
            .wr_data (wr_line[i*$bits(word_t) +: $bits(word_t)]),
            .rd_addr (rd_index),
            .rd_data (bank_q[i])
        );
    end

    simple_dual_port_ram #(
        .WIDTH ($bits(tagv_t)),
        .DEPTH (NUM_SETS)
    ) u_tagv (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_index),
        .wr_data (wr_tagv),
        .rd_addr (rd_index),
        .rd_data (tagv_q)
    );

    // valid and matching tag
    assign hit  = (tagv_q == {1'b1, cmp_tag});
    assign word = bank_q[word_sel];

endmodule

`default_nettype wire

/* pc_icache_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface pc_icache_if;
    import icache_pkg::*;

    addr_t pc;
    logic  inst_en;
    logic  stall;
    word_t inst;
    addr_t pc_out;
    logic  inst_valid;

    modport front (
        output pc,
        output inst_en,
        input  stall,
        input  inst,
        input  pc_out,
        input  inst_valid
    );

    modport cache (
        input  pc,
        input  inst_en,
        output stall,
        output inst,
        output pc_out,
        output inst_valid
    );

endinterface

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_fetch_top -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* simple_dual_port_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module simple_dual_port_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = icache_pkg::NUM_SETS
) (
    input  logic               clk,
    input  logic               wr_en,
    input  icache_pkg::index_t wr_addr,
    input  logic [WIDTH-1:0]   wr_data,
    input  icache_pkg::index_t rd_addr,
    output logic [WIDTH-1:0]   rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read always on, returns old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* tb.f */
icache_pkg.sv
pc_icache_if.sv
simple_dual_port_ram.sv
icache_way.sv
icache.sv
fetch_pc.sv
fetch_top.sv
fetch_checker.sv
tb_fetch_top.sv

/* tb_fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_top;

    localparam logic [31:0] RESET_PC  = 32'h1c00_0000;
    localparam logic [31:0] LOOP_BASE = 32'h1c00_0400;
    localparam logic [31:0] SET_BASE  = 32'h1c00_0800;
    localparam int          TIMEOUT   = 2000;

    logic         clk = 1'b0;
    logic         reset;
    logic         pause;
    logic         branch_flush;
    logic [31:0]  branch_target;
    logic         cacop_en;
    logic [1:0]   cacop_mode;
    logic [31:0]  cacop_addr;
    logic         rd_req;
    logic [31:0]  rd_addr;
    logic         ret_valid;
    logic [255:0] ret_data;
    logic [31:0]  inst;
    logic [31:0]  inst_pc;
    logic         inst_valid;

    logic [15:0] lfsr_q = 16'd5227;
    logic        mem_busy;
    int          mem_wait;
    logic        timed_out = 1'b0;
    int          tb_errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          err_mark;
    int          delta;

    always #20 clk = ~clk;

    fetch_top #(.RESET_PC(RESET_PC)) uut (
        .clk(clk), .reset(reset), .pause(pause), .branch_flush(branch_flush),
        .branch_target(branch_target), .cacop_en(cacop_en), .cacop_mode(cacop_mode),
        .cacop_addr(cacop_addr), .rd_req(rd_req), .rd_addr(rd_addr),
        .ret_valid(ret_valid), .ret_data(ret_data), .inst(inst), .inst_pc(inst_pc),
        .inst_valid(inst_valid)
    );

    fetch_checker #(.RESET_PC(RESET_PC)) u_check (
        .clk(clk), .reset(reset), .pause(pause), .branch_flush(branch_flush),
        .branch_target(branch_target), .cacop_en(cacop_en), .cacop_mode(cacop_mode),
        .cacop_addr(cacop_addr), .rd_req(rd_req), .rd_addr(rd_addr),
        .ret_valid(ret_valid), .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid)
    );

    // fibonacci lfsr, taps 16 14 13 11
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    function automatic logic [255:0] build_line(input logic [31:0] addr);
        logic [255:0] line;
        for (int i = 0; i < 8; i++) begin
            line[i*32 +: 32] = u_check.mem_word({addr[31:5], 3'(i), 2'b00});
        end
        return line;
    endfunction

    // memory answers 1 to 6 cycles after it sees rd_req
    always @(posedge clk) begin
        ret_valid <= 1'b0;
        if (reset) begin
            mem_busy = 1'b0;
            mem_wait = 0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                ret_valid <= 1'b1;
                ret_data  <= build_line(rd_addr);
                mem_busy = 1'b0;
            end else begin
                mem_wait--;
            end
        end else if (rd_req && !ret_valid) begin
            mem_busy = 1'b1;
            mem_wait = rand_bits(3) % 6;
        end
    end

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
        tb_errors++;
    endtask

    task automatic branch_to(input logic [31:0] target);
        @(posedge clk);
        branch_flush  <= 1'b1;
        branch_target <= target;
        @(posedge clk);
        branch_flush  <= 1'b0;
    endtask

    task automatic wait_pc(input logic [31:0] target);
        if (timed_out) begin
            return;
        end
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (inst_valid && inst_pc == target) begin
                return;
            end
        end
        report_timeout($sformatf("an instruction at %h", target));
    endtask

    task automatic wait_insts(input int count);
        int seen;
        seen = 0;
        if (timed_out) begin
            return;
        end
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (inst_valid) begin
                seen++;
            end
            if (seen == count) begin
                return;
            end
        end
        report_timeout($sformatf("%0d instructions", count));
    endtask

    // stop three words short so the next flush still lands inside the run
    task automatic run_from(input logic [31:0] target, input int nwords, output int refills);
        int base;
        branch_to(target);
        base = u_check.refills;
        wait_pc(target + 32'((nwords - 3) * 4));
        refills = u_check.refills - base;
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Fail %s expected %0d actual %0d", name, expected, actual);
            tb_errors++;
        end
    endtask

    task automatic start_test(input string name);
        u_check.test_name = name;
        err_mark = tb_errors + u_check.errors;
    endtask

    task automatic end_test(input string name);
        int n;
        @(posedge clk);
        n = tb_errors + u_check.errors - err_mark;
        tests++;
        if (n != 0) begin
            failed_tests++;
        end
        $display("%s: %s, %0d errors", name, (n == 0) ? "passed" : "failed", n);
    endtask

    initial begin
        reset         <= 1'b1;
        pause         <= 1'b0;
        branch_flush  <= 1'b0;
        branch_target <= '0;
        cacop_en      <= 1'b0;
        cacop_mode    <= '0;
        cacop_addr    <= '0;
        ret_valid     <= 1'b0;
        ret_data      <= '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        start_test("cold_sequential");
        wait_pc(RESET_PC + 32'(37 * 4));
        check_count("cold_sequential", 40 / 8, u_check.refills);
        end_test("cold_sequential");

        start_test("loop_reuse");
        for (int p = 0; p < 3; p++) begin
            run_from(LOOP_BASE, 24, delta);
            check_count("loop_reuse", (p == 0) ? 3 : 0, delta);
        end
        end_test("loop_reuse");

        // three tags in one set so the third evicts the first
        start_test("lru_evict");
        run_from(SET_BASE, 8, delta);
        check_count("lru_evict", 1, delta);
        run_from(SET_BASE + 32'h1_0000, 8, delta);
        check_count("lru_evict", 1, delta);
        run_from(SET_BASE + 32'h2_0000, 8, delta);
        check_count("lru_evict", 1, delta);
        run_from(SET_BASE + 32'h1_0000, 8, delta);
        check_count("lru_evict", 0, delta);
        run_from(SET_BASE, 8, delta);
        check_count("lru_evict", 1, delta);
        end_test("lru_evict");

        start_test("branch_redirect");
        branch_to(32'h1c00_0c00);
        wait_insts(5);
        branch_to(LOOP_BASE + 32'd32);
        wait_insts(6);
        // second redirect lands while the cold line is still missing
        branch_to(32'h1c00_0e00);
        repeat (3) @(posedge clk);
        branch_to(LOOP_BASE);
        wait_insts(4);
        end_test("branch_redirect");

        start_test("cache_op");
        for (int m = 0; m < 3; m++) begin
            branch_to(32'h1c00_3000 + 32'(m * 256));
            wait_insts(2);
            @(posedge clk);
            cacop_en   <= 1'b1;
            cacop_mode <= 2'(m);
            cacop_addr <= LOOP_BASE + 32'(m * 4);
            @(posedge clk);
            cacop_en   <= 1'b0;
            run_from(LOOP_BASE, 8, delta);
            check_count("cache_op", 1, delta);
        end
        end_test("cache_op");

        start_test("pause_pulses");
        branch_to(32'h1c00_1000);
        for (int c = 0; c < 80; c++) begin
            @(posedge clk);
            pause <= (rand_bits(2) == 0);
        end
        @(posedge clk);
        pause <= 1'b0;
        wait_insts(4);
        end_test("pause_pulses");

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests,
                 tb_errors + u_check.errors);
        if (!timed_out && failed_tests == 0 && tb_errors + u_check.errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
